// File: common/commit_settings.svh
`ifndef COMMIT_SETTINGS_SVH
`define COMMIT_SETTINGS_SVH

// datapath width
`define COMMIT_XLEN 32

// entry point for every exception
`define COMMIT_EXC_VECTOR 32'hbfc0_0380

// instructions per commit bundle
`define COMMIT_SLOTS 2

`endif

// File: common/commit_pkg.sv
`include "commit_settings.svh"

package commit_pkg;

    typedef logic [`COMMIT_XLEN-1:0] word_t;
    typedef logic [4:0]              reg_addr_t;
    typedef logic [1:0]              mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_t;

    // cp0 cause codes
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV   = 5'd12
    } exc_code_t;

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } commit_state_t;

    // redirect_kind encoding
    localparam logic [1:0] REDIR_NONE   = 2'd0;
    localparam logic [1:0] REDIR_EXC    = 2'd1;
    localparam logic [1:0] REDIR_ERET   = 2'd2;
    localparam logic [1:0] REDIR_BRANCH = 2'd3;

    function automatic logic op_is_load(mem_op_t op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

    function automatic logic op_is_store(mem_op_t op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage

// File: common/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if import commit_pkg::*; ();

    logic      en;
    logic      wt;
    mem_size_t size;
    word_t     addr;
    word_t     wd;
    // 1 when the access belongs to the older slot
    logic      mem_slot;

    modport formatter (
        output en, wt, size, addr, wd, mem_slot
    );

    modport ctrl (
        input en, mem_slot
    );

    // load path only needs the address and owner
    modport observer (
        input addr, mem_slot
    );

endinterface

// File: common/exc_if.sv
`timescale 1ns/1ps

interface exc_if import commit_pkg::*; ();

    logic      exc_valid;
    exc_code_t exc_code;
    word_t     bad_addr;
    word_t     exc_pc;

    modport chk (
        output exc_valid, exc_code, bad_addr, exc_pc
    );

    modport ctrl (
        input exc_valid, exc_code, bad_addr, exc_pc
    );

endinterface

// File: commit/exception_checker.sv
`timescale 1ns/1ps

module exception_checker import commit_pkg::*; (
    input  logic    check_en,
    input  logic    is_older,
    input  logic    int_pending,
    input  word_t   pc,
    input  mem_op_t mem_op,
    input  word_t   result,
    input  logic    overflow,
    exc_if.chk      rep
);

    logic half_op;
    logic word_op;
    logic misaligned;
    logic int_hit;
    logic ovf_hit;
    logic addr_hit;

    assign half_op    = mem_op inside {MEM_LH, MEM_LHU, MEM_SH};
    assign word_op    = mem_op inside {MEM_LW, MEM_SW};
    assign misaligned = (half_op && result[0]) || (word_op && result[1:0] != 2'b00);

    // interrupt is taken on the oldest instruction only
    assign int_hit  = check_en && is_older && int_pending;
    assign ovf_hit  = check_en && overflow;
    assign addr_hit = check_en && misaligned;

    always_comb begin
        rep.exc_code = EXC_INT;
        if (int_hit) begin
            rep.exc_code = EXC_INT;
        end else if (ovf_hit) begin
            rep.exc_code = EXC_OV;
        end else if (addr_hit) begin
            rep.exc_code = op_is_store(mem_op) ? EXC_ADES : EXC_ADEL;
        end
    end

    assign rep.exc_valid = int_hit || ovf_hit || addr_hit;
    // result holds the effective address for memory ops
    assign rep.bad_addr  = result;
    assign rep.exc_pc    = pc;

endmodule

// File: commit/commit_ctrl.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module commit_ctrl import commit_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  logic [`COMMIT_SLOTS-1:0] slot_valid,
    input  logic [`COMMIT_SLOTS-1:0] is_eret,
    exc_if.ctrl                      exc0,
    exc_if.ctrl                      exc1,
    mem_req_if.ctrl                  mem,
    input  logic                     dmem_data_ok,
    output logic [`COMMIT_SLOTS-1:0] slot_kill,
    output logic                     first_cycle,
    output logic                     finish,
    output logic                     exc_valid,
    output exc_code_t                exc_code,
    output word_t                    exc_bad_addr
);

    commit_state_t state;
    commit_state_t state_next;
    logic          older_flush;
    logic          exc0_live;
    logic          addr_fault;
    word_t         sel_bad_addr;
    word_t         sel_pc;

    // fault or eret in slot 1 flushes the younger slot
    assign older_flush = exc1.exc_valid || (slot_valid[1] && is_eret[1]);

    // bubbles count as killed so nothing downstream acts on them
    assign slot_kill[1] = !slot_valid[1] || exc1.exc_valid;
    assign slot_kill[0] = !slot_valid[0] || older_flush || exc0.exc_valid;

    assign exc0_live = exc0.exc_valid && !older_flush;

    assign first_cycle = (state == ST_IDLE);
    // data_ok during the request cycle itself is not taken
    assign finish = in_valid && (!mem.en || (!first_cycle && dmem_data_ok));

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (in_valid && mem.en) begin
                    state_next = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (dmem_data_ok) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // older slot wins
    assign exc_code     = exc1.exc_valid ? exc1.exc_code : exc0.exc_code;
    assign sel_bad_addr = exc1.exc_valid ? exc1.bad_addr : exc0.bad_addr;
    assign sel_pc       = exc1.exc_valid ? exc1.exc_pc : exc0.exc_pc;
    assign addr_fault   = exc_code inside {EXC_ADEL, EXC_ADES};
    // non-address faults report the instruction pc
    assign exc_bad_addr = addr_fault ? sel_bad_addr : sel_pc;
    assign exc_valid    = finish && (exc1.exc_valid || exc0_live);

    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        state == ST_WAIT && !dmem_data_ok |=> mem.en && $stable(mem.mem_slot))
        else $error("dmem request dropped before dmem_data_ok");

    // a memory bundle must already have been pending one cycle earlier
    a_no_early_finish: assert property (@(posedge clk) disable iff (!arst_n)
        finish && mem.en |-> $past(in_valid && mem.en && !finish))
        else $error("finish in the request cycle of a memory bundle");

    a_kill_order: assert property (@(posedge clk) disable iff (!arst_n)
        slot_valid[1] && slot_kill[1] |-> !(mem.en && !mem.mem_slot))
        else $error("slot 0 access issued while slot 1 is killed");

endmodule

// File: logic/store_formatter.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module store_formatter import commit_pkg::*; (
    input  logic                        in_valid,
    input  logic                        first_cycle,
    input  mem_op_t [`COMMIT_SLOTS-1:0] mem_op,
    input  word_t   [`COMMIT_SLOTS-1:0] result,
    input  word_t   [`COMMIT_SLOTS-1:0] store_data,
    input  logic    [`COMMIT_SLOTS-1:0] slot_kill,
    mem_req_if.formatter                req
);

    logic    sel;
    mem_op_t op;
    word_t   data;

    // older slot first
    assign sel  = (mem_op[1] != MEM_NONE);
    assign op   = mem_op[sel];
    assign data = store_data[sel];

    assign req.mem_slot = sel;
    assign req.addr     = result[sel];
    assign req.wt       = op_is_store(op);
    assign req.en       = in_valid && (op != MEM_NONE) && !slot_kill[sel];

    always_comb begin
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: req.size = SIZE_BYTE;
            MEM_LH, MEM_LHU, MEM_SH: req.size = SIZE_HALF;
            default:                 req.size = SIZE_WORD;
        endcase
    end

    // replicate so every byte lane carries the data
    always_comb begin
        case (op)
            MEM_SB:  req.wd = {4{data[7:0]}};
            MEM_SH:  req.wd = {2{data[15:0]}};
            default: req.wd = data;
        endcase
    end

    // one memory port per bundle
    always_comb begin
        if (in_valid && first_cycle) begin
            assert (mem_op[1] == MEM_NONE || mem_op[0] == MEM_NONE)
                else $error("both slots carry a memory operation");
        end
    end

endmodule

// File: logic/load_formatter.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module load_formatter import commit_pkg::*; (
    input  logic                          finish,
    input  logic      [`COMMIT_SLOTS-1:0] slot_valid,
    input  logic      [`COMMIT_SLOTS-1:0] slot_kill,
    input  logic      [`COMMIT_SLOTS-1:0] reg_write,
    input  reg_addr_t [`COMMIT_SLOTS-1:0] dest,
    input  word_t     [`COMMIT_SLOTS-1:0] result,
    input  mem_op_t   [`COMMIT_SLOTS-1:0] mem_op,
    input  word_t                         dmem_rd,
    mem_req_if.observer                   mem,
    output logic      [`COMMIT_SLOTS-1:0] wb_en,
    output reg_addr_t [`COMMIT_SLOTS-1:0] wb_dest,
    output word_t     [`COMMIT_SLOTS-1:0] wb_data
);

    mem_op_t ld_op;
    word_t   lane;
    word_t   ld_val;

    assign ld_op = mem_op[mem.mem_slot];
    // addressed byte or half moved down to bit 0
    assign lane  = dmem_rd >> {mem.addr[1:0], 3'b000};

    always_comb begin
        case (ld_op)
            MEM_LB:  ld_val = {{(`COMMIT_XLEN-8){lane[7]}}, lane[7:0]};
            MEM_LBU: ld_val = {{(`COMMIT_XLEN-8){1'b0}}, lane[7:0]};
            MEM_LH:  ld_val = {{(`COMMIT_XLEN-16){lane[15]}}, lane[15:0]};
            MEM_LHU: ld_val = {{(`COMMIT_XLEN-16){1'b0}}, lane[15:0]};
            default: ld_val = lane;
        endcase
    end

    always_comb begin
        for (int i = 0; i < `COMMIT_SLOTS; i++) begin
            wb_en[i]   = finish && slot_valid[i] && !slot_kill[i] && reg_write[i];
            wb_dest[i] = finish ? dest[i] : '0;
            wb_data[i] = '0;
            if (finish) begin
                if (mem.mem_slot == 1'(i) && op_is_load(mem_op[i])) begin
                    wb_data[i] = ld_val;
                end else begin
                    wb_data[i] = result[i];
                end
            end
        end
    end

endmodule

// File: logic/redirect_unit.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module redirect_unit import commit_pkg::*; (
    input  logic                      finish,
    input  logic                      exc_valid,
    input  logic  [`COMMIT_SLOTS-1:0] slot_kill,
    input  logic  [`COMMIT_SLOTS-1:0] is_eret,
    input  logic  [`COMMIT_SLOTS-1:0] is_branch,
    input  logic  [`COMMIT_SLOTS-1:0] taken,
    input  logic  [`COMMIT_SLOTS-1:0] pred,
    input  word_t [`COMMIT_SLOTS-1:0] pc,
    input  word_t [`COMMIT_SLOTS-1:0] branch_target,
    input  word_t                     epc,
    output logic                      redirect_valid,
    output logic  [1:0]               redirect_kind,
    output word_t                     redirect_pc,
    output logic                      bpb_wen,
    output word_t                     bpb_pc,
    output logic                      bpb_taken,
    output word_t                     bpb_target
);

    logic [`COMMIT_SLOTS-1:0] live;
    logic                     eret_hit;
    logic                     branch_live;
    logic                     mispredict;

    assign live        = ~slot_kill;
    assign eret_hit    = |(is_eret & live);
    assign branch_live = live[1] && is_branch[1];
    assign mispredict  = branch_live && (taken[1] != pred[1]);

    always_comb begin
        redirect_valid = 1'b0;
        redirect_kind  = REDIR_NONE;
        redirect_pc    = '0;
        if (finish) begin
            if (exc_valid) begin
                redirect_valid = 1'b1;
                redirect_kind  = REDIR_EXC;
                redirect_pc    = `COMMIT_EXC_VECTOR;
            end else if (eret_hit) begin
                redirect_valid = 1'b1;
                redirect_kind  = REDIR_ERET;
                redirect_pc    = epc;
            end else if (mispredict) begin
                redirect_valid = 1'b1;
                redirect_kind  = REDIR_BRANCH;
                // not taken resumes after the delay slot
                redirect_pc    = taken[1] ? branch_target[1] : pc[0] + word_t'(4);
            end
        end
    end

    assign bpb_wen    = finish && branch_live;
    assign bpb_pc     = pc[1];
    assign bpb_taken  = taken[1];
    assign bpb_target = branch_target[1];

endmodule

// File: commit/commit_stage.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module commit_stage import commit_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  logic                          int_pending,
    input  logic      [`COMMIT_SLOTS-1:0] slot_valid,
    input  word_t     [`COMMIT_SLOTS-1:0] pc,
    input  mem_op_t   [`COMMIT_SLOTS-1:0] mem_op,
    input  word_t     [`COMMIT_SLOTS-1:0] result,
    input  word_t     [`COMMIT_SLOTS-1:0] store_data,
    input  reg_addr_t [`COMMIT_SLOTS-1:0] dest,
    input  logic      [`COMMIT_SLOTS-1:0] reg_write,
    input  logic      [`COMMIT_SLOTS-1:0] overflow,
    input  logic      [`COMMIT_SLOTS-1:0] is_eret,
    input  logic      [`COMMIT_SLOTS-1:0] is_branch,
    input  logic      [`COMMIT_SLOTS-1:0] taken,
    input  logic      [`COMMIT_SLOTS-1:0] pred,
    input  word_t     [`COMMIT_SLOTS-1:0] branch_target,
    input  word_t                         epc,
    output logic                          finish,
    output logic                          dmem_en,
    output logic                          dmem_wt,
    output mem_size_t                     dmem_size,
    output word_t                         dmem_addr,
    output word_t                         dmem_wd,
    input  word_t                         dmem_rd,
    input  logic                          dmem_data_ok,
    output logic      [`COMMIT_SLOTS-1:0] wb_en,
    output reg_addr_t [`COMMIT_SLOTS-1:0] wb_dest,
    output word_t     [`COMMIT_SLOTS-1:0] wb_data,
    output logic                          exc_valid,
    output exc_code_t                     exc_code,
    output word_t                         exc_bad_addr,
    output logic                          redirect_valid,
    output logic      [1:0]               redirect_kind,
    output word_t                         redirect_pc,
    output logic                          bpb_wen,
    output word_t                         bpb_pc,
    output logic                          bpb_taken,
    output word_t                         bpb_target
);

    logic [`COMMIT_SLOTS-1:0] slot_kill;
    logic                     first_cycle;

    exc_if     exc1_rep ();
    exc_if     exc0_rep ();
    mem_req_if mem_req ();

    exception_checker u_exc1 (
        .check_en    (slot_valid[1]),
        .is_older    (1'b1),
        .int_pending (int_pending),
        .pc          (pc[1]),
        .mem_op      (mem_op[1]),
        .result      (result[1]),
        .overflow    (overflow[1]),
        .rep         (exc1_rep)
    );

    // slot 0 is the oldest when slot 1 is a bubble
    exception_checker u_exc0 (
        .check_en    (slot_valid[0]),
        .is_older    (!slot_valid[1]),
        .int_pending (int_pending),
        .pc          (pc[0]),
        .mem_op      (mem_op[0]),
        .result      (result[0]),
        .overflow    (overflow[0]),
        .rep         (exc0_rep)
    );

    commit_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .slot_valid   (slot_valid),
        .is_eret      (is_eret),
        .exc0         (exc0_rep),
        .exc1         (exc1_rep),
        .mem          (mem_req),
        .dmem_data_ok (dmem_data_ok),
        .slot_kill    (slot_kill),
        .first_cycle  (first_cycle),
        .finish       (finish),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .exc_bad_addr (exc_bad_addr)
    );

    store_formatter u_store (
        .in_valid    (in_valid),
        .first_cycle (first_cycle),
        .mem_op      (mem_op),
        .result      (result),
        .store_data  (store_data),
        .slot_kill   (slot_kill),
        .req         (mem_req)
    );

    load_formatter u_load (
        .finish     (finish),
        .slot_valid (slot_valid),
        .slot_kill  (slot_kill),
        .reg_write  (reg_write),
        .dest       (dest),
        .result     (result),
        .mem_op     (mem_op),
        .dmem_rd    (dmem_rd),
        .mem        (mem_req),
        .wb_en      (wb_en),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data)
    );

    redirect_unit u_redirect (
        .finish         (finish),
        .exc_valid      (exc_valid),
        .slot_kill      (slot_kill),
        .is_eret        (is_eret),
        .is_branch      (is_branch),
        .taken          (taken),
        .pred           (pred),
        .pc             (pc),
        .branch_target  (branch_target),
        .epc            (epc),
        .redirect_valid (redirect_valid),
        .redirect_kind  (redirect_kind),
        .redirect_pc    (redirect_pc),
        .bpb_wen        (bpb_wen),
        .bpb_pc         (bpb_pc),
        .bpb_taken      (bpb_taken),
        .bpb_target     (bpb_target)
    );

    assign dmem_en   = mem_req.en;
    assign dmem_wt   = mem_req.wt;
    assign dmem_size = mem_req.size;
    assign dmem_addr = mem_req.addr;
    assign dmem_wd   = mem_req.wd;

endmodule

// File: tb/tb_commit_stage.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module tb_commit_stage import commit_pkg::*; ();

    localparam int          BUNDLES     = 400;
    localparam int          WATCHDOG_NS = (8 + BUNDLES * 6) * 40;
    localparam logic [31:0] SEED        = 32'hc5be_1862;

    logic clk = 1'b0;
    logic arst_n = 1'b0;
    logic in_valid = 1'b0;
    logic int_pending = 1'b0;
    logic [1:0] slot_valid = '0;
    word_t [1:0] pc = '0;
    mem_op_t [1:0] mem_op = {MEM_NONE, MEM_NONE};
    word_t [1:0] result = '0;
    word_t [1:0] store_data = '0;
    reg_addr_t [1:0] dest = '0;
    logic [1:0] reg_write = '0;
    logic [1:0] overflow = '0;
    logic [1:0] is_eret = '0;
    logic [1:0] is_branch = '0;
    logic [1:0] taken = '0;
    logic [1:0] pred = '0;
    word_t [1:0] branch_target = '0;
    word_t epc = '0;
    word_t dmem_rd = '0;
    logic dmem_data_ok = 1'b0;
    logic [2:0] reply_delay = 3'd1;
    logic [2:0] mem_age = '0;
    int errors = 0;

    logic finish, dmem_en, dmem_wt, exc_valid, redirect_valid, bpb_wen, bpb_taken;
    mem_size_t dmem_size;
    word_t dmem_addr, dmem_wd, exc_bad_addr, redirect_pc, bpb_pc, bpb_target;
    logic [1:0] wb_en, redirect_kind;
    reg_addr_t [1:0] wb_dest;
    word_t [1:0] wb_data;
    exc_code_t exc_code;

    // expected view of the current bundle
    logic [1:0] older, mis, exc, live, pass_ok;
    logic flush0, exc_any, eret_live, misp, mem_live, ms, es;
    mem_op_t op_m;
    word_t addr_m, sd_m, exp_bad;
    exc_code_t exp_code;

    commit_stage uut (.*);

    always #20 clk = ~clk;

    function automatic word_t mem_word(word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic reads_memory(mem_op_t op);
        return op == MEM_LB || op == MEM_LBU || op == MEM_LH || op == MEM_LHU || op == MEM_LW;
    endfunction

    function automatic logic writes_memory(mem_op_t op);
        return op == MEM_SB || op == MEM_SH || op == MEM_SW;
    endfunction

    function automatic logic bad_align(mem_op_t op, word_t a);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: return a[0];
            MEM_LW, MEM_SW:          return a[1:0] != 2'b00;
            default:                 return 1'b0;
        endcase
    endfunction

    function automatic mem_size_t size_of(mem_op_t op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 2'd0;
            MEM_LH, MEM_LHU, MEM_SH: return 2'd1;
            default:                 return 2'd2;
        endcase
    endfunction

    function automatic word_t lanes_of(mem_op_t op, word_t d);
        case (op)
            MEM_SB:  return {d[7:0], d[7:0], d[7:0], d[7:0]};
            MEM_SH:  return {d[15:0], d[15:0]};
            default: return d;
        endcase
    endfunction

    function automatic word_t extend_load(mem_op_t op, word_t a, word_t w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{a[1:0], 3'b000} +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'd0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'd0, h};
            default: return w;
        endcase
    endfunction

    // mostly aligned, now and then misaligned
    function automatic word_t pick_addr(mem_op_t op);
        word_t a;
        a = $urandom();
        if ($urandom_range(0, 5) != 0) begin
            if (op == MEM_LH || op == MEM_LHU || op == MEM_SH) begin
                a[0] = 1'b0;
            end else if (op == MEM_LW || op == MEM_SW) begin
                a[1:0] = 2'b00;
            end
        end
        return a;
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    always_comb begin
        ms     = (mem_op[1] != MEM_NONE);
        op_m   = mem_op[ms];
        addr_m = result[ms];
        sd_m   = store_data[ms];
        for (int s = 0; s < 2; s++) begin
            older[s] = (s == 1) || !slot_valid[1];
            mis[s]   = bad_align(mem_op[s], result[s]);
            exc[s]   = slot_valid[s] && ((int_pending && older[s]) || overflow[s] || mis[s]);
            // every written slot except the load slot returns its result
            pass_ok[s] = !wb_en[s] || (ms == 1'(s) && reads_memory(op_m)) ||
                         wb_data[s] == result[s];
        end
        flush0    = exc[1] || (slot_valid[1] && is_eret[1]);
        live[1]   = slot_valid[1] && !exc[1];
        live[0]   = slot_valid[0] && !exc[0] && !flush0;
        exc_any   = exc[1] || (exc[0] && !flush0);
        eret_live = |(live & is_eret);
        misp      = live[1] && is_branch[1] && (taken[1] != pred[1]);
        mem_live  = in_valid && op_m != MEM_NONE && live[ms];
        es        = exc[1];
        exp_bad   = result[es];
        if (int_pending && older[es]) begin
            exp_code = EXC_INT;
        end else if (overflow[es]) begin
            exp_code = EXC_OV;
        end else begin
            exp_code = writes_memory(mem_op[es]) ? EXC_ADES : EXC_ADEL;
        end
    end

    // data memory with a per-bundle reply delay
    always @(posedge clk) begin
        if (!arst_n || dmem_data_ok) begin
            dmem_data_ok <= 1'b0;
            mem_age      <= '0;
        end else if (dmem_en) begin
            mem_age <= mem_age + 3'd1;
            if (mem_age + 3'd1 >= reply_delay) begin
                dmem_data_ok <= 1'b1;
                dmem_rd      <= mem_word(dmem_addr);
            end
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !finish |-> !wb_en && !exc_valid && !redirect_valid && !bpb_wen)
        else log_error("outputs active without finish");
    a_req_en: assert property (@(posedge clk) disable iff (!arst_n) dmem_en == mem_live)
        else log_error("dmem_en does not match a surviving memory access");
    a_store: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_en && writes_memory(op_m) |->
            dmem_wt && dmem_size == size_of(op_m) && dmem_addr == addr_m &&
            dmem_wd == lanes_of(op_m, sd_m))
        else log_error("store request fields wrong");
    a_load_req: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_en && reads_memory(op_m) |->
            !dmem_wt && dmem_size == size_of(op_m) && dmem_addr == addr_m)
        else log_error("load request fields wrong");
    a_load: assert property (@(posedge clk) disable iff (!arst_n)
        finish && mem_live && reads_memory(op_m) |->
            wb_data[ms] == extend_load(op_m, addr_m, mem_word(addr_m)))
        else log_error("load data not aligned or extended");
    a_wb: assert property (@(posedge clk) disable iff (!arst_n)
        finish |-> wb_en == (live & reg_write) && wb_dest == dest)
        else log_error("write-back enable or destination wrong");
    a_pass: assert property (@(posedge clk) disable iff (!arst_n)
        finish |-> pass_ok == 2'b11)
        else log_error("pass-through write-back data wrong");
    a_fast: assert property (@(posedge clk) disable iff (!arst_n) in_valid && !mem_live |-> finish)
        else log_error("bundle without memory access did not finish at once");
    a_wait: assert property (@(posedge clk) disable iff (!arst_n)
        mem_live && !dmem_data_ok |-> !finish)
        else log_error("finish before dmem_data_ok");
    a_done: assert property (@(posedge clk) disable iff (!arst_n)
        mem_live && dmem_data_ok |-> finish)
        else log_error("no finish with dmem_data_ok");
    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_en && !dmem_data_ok |=> dmem_en)
        else log_error("dmem_en dropped before dmem_data_ok");
    a_exc: assert property (@(posedge clk) disable iff (!arst_n) finish |-> exc_valid == exc_any)
        else log_error("exception flag wrong");
    a_exc_code: assert property (@(posedge clk) disable iff (!arst_n)
        finish && exc_any |-> exc_code == exp_code && redirect_valid &&
            redirect_kind == REDIR_EXC && redirect_pc == `COMMIT_EXC_VECTOR)
        else log_error("exception code or vector wrong");
    a_exc_addr: assert property (@(posedge clk) disable iff (!arst_n)
        finish && exc_any && exp_code inside {EXC_ADEL, EXC_ADES} |-> exc_bad_addr == exp_bad)
        else log_error("bad address wrong");
    a_eret: assert property (@(posedge clk) disable iff (!arst_n)
        finish && !exc_any && eret_live |->
            redirect_valid && redirect_kind == REDIR_ERET && redirect_pc == epc)
        else log_error("eret redirect wrong");
    a_misp: assert property (@(posedge clk) disable iff (!arst_n)
        finish && !exc_any && !eret_live && misp |->
            redirect_valid && redirect_kind == REDIR_BRANCH &&
            redirect_pc == (taken[1] ? branch_target[1] : pc[0] + 32'd4))
        else log_error("mispredict redirect wrong");
    a_no_redir: assert property (@(posedge clk) disable iff (!arst_n)
        finish && !exc_any && !eret_live && !misp |-> !redirect_valid)
        else log_error("unexpected redirect");
    a_bpb: assert property (@(posedge clk) disable iff (!arst_n)
        finish |-> bpb_wen == (live[1] && is_branch[1]))
        else log_error("predictor update enable wrong");
    a_bpb_data: assert property (@(posedge clk) disable iff (!arst_n)
        bpb_wen |-> bpb_pc == pc[1] && bpb_taken == taken[1] && bpb_target == branch_target[1])
        else log_error("predictor update fields wrong");

    task automatic drive_bundle();
        mem_op_t op;
        logic    mslot;
        word_t   addr;
        word_t   base_pc;
        int      kind;
        base_pc = $urandom() & ~32'h3;
        kind    = $urandom_range(0, 3);
        op      = MEM_NONE;
        if (kind >= 2) begin
            op = mem_op_t'(4'($urandom_range(1, 8)));
        end
        mslot = (kind == 3);
        addr  = pick_addr(op);
        in_valid      <= 1'b1;
        int_pending   <= ($urandom_range(0, 31) == 0);
        slot_valid    <= {$urandom_range(0, 7) != 0, $urandom_range(0, 7) != 0};
        pc            <= {base_pc, base_pc + 32'd4};
        mem_op        <= mslot ? {op, MEM_NONE} : {MEM_NONE, op};
        result        <= mslot ? {addr, word_t'($urandom())} : {word_t'($urandom()), addr};
        store_data    <= {$urandom(), $urandom()};
        dest          <= 10'($urandom());
        reg_write     <= 2'($urandom());
        overflow      <= {$urandom_range(0, 31) == 0, $urandom_range(0, 31) == 0};
        is_eret       <= {$urandom_range(0, 15) == 0, $urandom_range(0, 15) == 0};
        is_branch     <= 2'($urandom());
        taken         <= 2'($urandom());
        pred          <= 2'($urandom());
        branch_target <= {$urandom() & ~32'h3, $urandom() & ~32'h3};
        epc           <= $urandom() & ~32'h3;
        reply_delay   <= 3'($urandom_range(1, 4));
    endtask

    task automatic wait_finish();
        @(negedge clk);
        while (!finish) begin
            @(negedge clk);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: a bundle never reached finish");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < BUNDLES; n++) begin
            @(posedge clk);
            drive_bundle();
            wait_finish();
            // occasional idle cycle between bundles
            if ($urandom_range(0, 7) == 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (2) @(posedge clk);
        $display("bundles: %0d, errors: %0d", BUNDLES, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+common
common/commit_pkg.sv
common/mem_req_if.sv
common/exc_if.sv
commit/exception_checker.sv
commit/commit_ctrl.sv
logic/store_formatter.sv
logic/load_formatter.sv
logic/redirect_unit.sv
commit/commit_stage.sv
tb/tb_commit_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_commit_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
